/* Makefile */
VERILATOR ?= verilator
TOP       ?= camera_pipeline_tb
RTL_TOP   ?= camera_pipeline
FILELIST  ?= camera_pipeline.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F "** PASS **" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* camera_pipeline.f */
logic/capture_pkg.sv
logic/camera_sync.sv
logic/pixel_reconstruct.sv
logic/chunk_stacker.sv
logic/chunk_unstacker.sv
logic/color_threshold.sv
logic/stream_reg.sv
logic/camera_pipeline.sv
testbench/camera_checker.sv
testbench/camera_pipeline_tb.sv

/* logic/camera_pipeline.sv */
module camera_pipeline (
  input  logic                       clk_camera,
  input  logic                       recent_reset,
  // capture side
  input  capture_pkg::camera_bus_t   cam_bus_i,
  output logic                       chunk_valid_o,   // dram write stream
  input  logic                       chunk_ready_i,
  output capture_pkg::chunk_t        chunk_o,
  output logic                       overflow_o,
  // display side
  input  logic                       chunk_valid_i,   // dram read stream
  output logic                       chunk_ready_o,
  input  capture_pkg::chunk_t        chunk_i,
  input  capture_pkg::threshold_t    cutoff_i,
  output logic                       pixel_valid_o,
  input  logic                       pixel_ready_i,
  output capture_pkg::masked_pixel_t pixel_o
);

  capture_pkg::camera_bus_t   cam_sync;
  logic                       cap_valid;
  capture_pkg::pixel_beat_t   cap_beat;
  logic                       stk_valid;
  logic                       stk_ready;
  capture_pkg::chunk_t        stk_chunk;
  logic                       unstk_valid;
  logic                       unstk_ready;
  capture_pkg::pixel_beat_t   unstk_beat;
  logic                       thr_valid;
  logic                       thr_ready;
  capture_pkg::masked_pixel_t thr_pix;

  camera_sync sync_inst (
    .clk_camera (clk_camera),
    .cam_bus_i  (cam_bus_i),
    .cam_bus_o  (cam_sync)
  );

  pixel_reconstruct recon_inst (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .cam_bus_i    (cam_sync),
    .beat_valid_o (cap_valid),
    .beat_o       (cap_beat)
  );

  chunk_stacker stacker_inst (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .beat_valid_i  (cap_valid),
    .beat_i        (cap_beat),
    .chunk_valid_o (stk_valid),
    .chunk_ready_i (stk_ready),
    .chunk_o       (stk_chunk),
    .overflow_o    (overflow_o)
  );

  // slice before the write port
  stream_reg #(.payload_t(capture_pkg::chunk_t)) chunk_reg_inst (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .valid_i      (stk_valid),
    .ready_o      (stk_ready),
    .data_i       (stk_chunk),
    .valid_o      (chunk_valid_o),
    .ready_i      (chunk_ready_i),
    .data_o       (chunk_o)
  );

  chunk_unstacker unstacker_inst (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .chunk_valid_i (chunk_valid_i),
    .chunk_ready_o (chunk_ready_o),
    .chunk_i       (chunk_i),
    .beat_valid_o  (unstk_valid),
    .beat_ready_i  (unstk_ready),
    .beat_o        (unstk_beat)
  );

  color_threshold thresh_inst (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .beat_valid_i (unstk_valid),
    .beat_ready_o (unstk_ready),
    .beat_i       (unstk_beat),
    .cutoff_i     (cutoff_i),
    .pix_valid_o  (thr_valid),
    .pix_ready_i  (thr_ready),
    .pix_o        (thr_pix)
  );

  // second registered stage on the pixel output
  stream_reg #(.payload_t(capture_pkg::masked_pixel_t)) pixel_reg_inst (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .valid_i      (thr_valid),
    .ready_o      (thr_ready),
    .data_i       (thr_pix),
    .valid_o      (pixel_valid_o),
    .ready_i      (pixel_ready_i),
    .data_o       (pixel_o)
  );

endmodule

/* logic/camera_sync.sv */
module camera_sync (
  input  logic                     clk_camera,
  input  capture_pkg::camera_bus_t cam_bus_i,   // straight from the pins
  output capture_pkg::camera_bus_t cam_bus_o
);

  // flop chain, stage 0 is the one that may go metastable
  capture_pkg::camera_bus_t sync_q [capture_pkg::SYNC_STAGES];

  always_ff @(posedge clk_camera) begin
    sync_q[0] <= cam_bus_i;
    for (int i = 1; i < capture_pkg::SYNC_STAGES; i++) begin
      sync_q[i] <= sync_q[i-1];   // settle one more cycle
    end
  end

  // whole bus moves together so data lines up with pclk
  assign cam_bus_o = sync_q[capture_pkg::SYNC_STAGES-1];

endmodule

/* logic/capture_pkg.sv */
package capture_pkg;

  // pixel and memory geometry
  localparam int PIXEL_W          = 16;                  // rgb565
  localparam int CHUNK_W          = 128;                 // one dram word
  localparam int PIXELS_PER_CHUNK = CHUNK_W / PIXEL_W;   // 8 slices per chunk
  localparam int SLICE_W          = $clog2(PIXELS_PER_CHUNK);
  localparam logic [SLICE_W-1:0] SLICE_LAST = SLICE_W'(PIXELS_PER_CHUNK - 1);

  // frame size, shrunk for simulation (camera runs 1280 x 720)
  localparam int FRAME_WIDTH  = 16;
  localparam int FRAME_HEIGHT = 4;
  localparam int HCOUNT_W     = $clog2(FRAME_WIDTH);
  localparam int VCOUNT_W     = $clog2(FRAME_HEIGHT);
  localparam logic [HCOUNT_W-1:0] HCOUNT_LAST = HCOUNT_W'(FRAME_WIDTH - 1);
  localparam logic [VCOUNT_W-1:0] VCOUNT_LAST = VCOUNT_W'(FRAME_HEIGHT - 1);

  localparam int SYNC_STAGES = 2;   // flops in front of the edge detector
  localparam int CHANNEL_W   = 8;   // expanded colour channel

  // raw parallel camera pins
  typedef struct packed {
    logic [7:0] data;
    logic       pclk;
    logic       hsync;
    logic       vsync;
  } camera_bus_t;

  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565_t;

  // one pixel with its raster position
  typedef struct packed {
    rgb565_t             pixel;
    logic [HCOUNT_W-1:0] hcount;
    logic [VCOUNT_W-1:0] vcount;
    logic                last;    // final pixel of the frame
  } pixel_beat_t;

  typedef struct packed {
    logic [CHUNK_W-1:0] data;     // slice 0 in the low bits
    logic               last;
  } chunk_t;

  // per-channel lower bounds
  typedef struct packed {
    logic [CHANNEL_W-1:0] red;
    logic [CHANNEL_W-1:0] green;
    logic [CHANNEL_W-1:0] blue;
  } threshold_t;

  typedef struct packed {
    logic [CHANNEL_W-1:0] red;
    logic [CHANNEL_W-1:0] green;
    logic [CHANNEL_W-1:0] blue;
    logic                 mask;
    logic                 last;
  } masked_pixel_t;

endpackage

/* logic/chunk_stacker.sv */
module chunk_stacker (
  input  logic                     clk_camera,
  input  logic                     recent_reset,
  input  logic                     beat_valid_i,   // camera cannot be held off
  input  capture_pkg::pixel_beat_t beat_i,
  output logic                     chunk_valid_o,
  input  logic                     chunk_ready_i,
  output capture_pkg::chunk_t      chunk_o,        // doubles as the holding register
  output logic                     overflow_o      // sticky until reset
);

  localparam int GATHER_W = capture_pkg::CHUNK_W - capture_pkg::PIXEL_W;

  logic [capture_pkg::SLICE_W-1:0] slot_q;
  logic [capture_pkg::SLICE_W-1:0] slot_tgt;
  logic [GATHER_W-1:0]             gather_q;   // slices 0..6 of the next chunk

  logic sof;
  logic slot_full;
  logic hold_free;
  logic accept;
  logic drop;

  // first pixel of a frame always restarts at slice 0
  assign sof       = (beat_i.hcount == '0) && (beat_i.vcount == '0);
  assign slot_tgt  = sof ? '0 : slot_q;
  assign slot_full = (slot_tgt == capture_pkg::SLICE_LAST);

  // completed chunk needs the holding slot, either empty or leaving now
  assign hold_free = !chunk_valid_o || chunk_ready_i;
  assign accept    = beat_valid_i && (!slot_full || hold_free);
  assign drop      = beat_valid_i && !accept;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      slot_q        <= '0;
      chunk_valid_o <= 1'b0;
      overflow_o    <= 1'b0;
    end else begin
      if (chunk_valid_o && chunk_ready_i) chunk_valid_o <= 1'b0;
      if (accept) begin
        slot_q <= slot_tgt + 1'b1;           // wraps back to slice 0
        if (slot_full) chunk_valid_o <= 1'b1;
      end
      if (drop) overflow_o <= 1'b1;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (accept && !slot_full) begin
      gather_q[slot_tgt * capture_pkg::PIXEL_W +: capture_pkg::PIXEL_W] <= beat_i.pixel;
    end
    if (accept && slot_full) begin
      // last slice goes on top, straight into the holding register
      chunk_o.data <= {beat_i.pixel, gather_q};
      chunk_o.last <= beat_i.last;
    end
  end

endmodule

/* logic/chunk_unstacker.sv */
module chunk_unstacker (
  input  logic                     clk_camera,
  input  logic                     recent_reset,
  input  logic                     chunk_valid_i,
  output logic                     chunk_ready_o,
  input  capture_pkg::chunk_t      chunk_i,
  output logic                     beat_valid_o,
  input  logic                     beat_ready_i,
  output capture_pkg::pixel_beat_t beat_o
);

  capture_pkg::chunk_t             hold_q;
  logic [capture_pkg::SLICE_W-1:0] slice_q;   // next slice to hand out
  logic                            full_q;
  logic                            live_q;    // one cycle after reset

  logic last_slice;
  logic chunk_take;
  logic beat_take;

  assign last_slice = (slice_q == capture_pkg::SLICE_LAST);
  assign beat_take  = full_q && beat_ready_i;

  // empty, or the final slice leaves this cycle
  assign chunk_ready_o = live_q && (!full_q || (beat_ready_i && last_slice));
  assign chunk_take    = chunk_valid_i && chunk_ready_o;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      live_q  <= 1'b0;
      full_q  <= 1'b0;
      slice_q <= '0;
    end else begin
      live_q <= 1'b1;
      if (chunk_take) begin
        full_q  <= 1'b1;
        slice_q <= '0;
      end else if (beat_take) begin
        slice_q <= slice_q + 1'b1;
        if (last_slice) full_q <= 1'b0;   // chunk used up
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (chunk_take) hold_q <= chunk_i;
  end

  // lowest slice first
  assign beat_valid_o = full_q;
  assign beat_o.pixel = hold_q.data[slice_q * capture_pkg::PIXEL_W +: capture_pkg::PIXEL_W];
  assign beat_o.hcount = '0;   // no raster on the read side
  assign beat_o.vcount = '0;
  assign beat_o.last   = hold_q.last && last_slice;

endmodule

/* logic/color_threshold.sv */
module color_threshold (
  input  logic                       clk_camera,
  input  logic                       recent_reset,
  input  logic                       beat_valid_i,
  output logic                       beat_ready_o,
  input  capture_pkg::pixel_beat_t   beat_i,
  input  capture_pkg::threshold_t    cutoff_i,      // static, switch style
  output logic                       pix_valid_o,
  input  logic                       pix_ready_i,
  output capture_pkg::masked_pixel_t pix_o
);

  logic [capture_pkg::CHANNEL_W-1:0] red8;
  logic [capture_pkg::CHANNEL_W-1:0] green8;
  logic [capture_pkg::CHANNEL_W-1:0] blue8;
  logic                              mask;

  // channel in the msbs, zeros below
  assign red8   = {beat_i.pixel.red, 3'b000};
  assign green8 = {beat_i.pixel.green, 2'b00};
  assign blue8  = {beat_i.pixel.blue, 3'b000};

  // every channel must clear its cutoff
  assign mask = (red8 >= cutoff_i.red) && (green8 >= cutoff_i.green) &&
                (blue8 >= cutoff_i.blue);

  // stage can load whenever its current result is gone or leaving
  assign beat_ready_o = !pix_valid_o || pix_ready_i;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pix_valid_o <= 1'b0;
    end else if (beat_ready_o) begin
      pix_valid_o <= beat_valid_i;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (beat_valid_i && beat_ready_o) begin
      pix_o.red   <= red8;
      pix_o.green <= green8;
      pix_o.blue  <= blue8;
      pix_o.mask  <= mask;
      pix_o.last  <= beat_i.last;
    end
  end

endmodule

/* logic/pixel_reconstruct.sv */
module pixel_reconstruct (
  input  logic                     clk_camera,
  input  logic                     recent_reset,
  input  capture_pkg::camera_bus_t cam_bus_i,      // already synchronized
  output logic                     beat_valid_o,   // single cycle, no stall
  output capture_pkg::pixel_beat_t beat_o
);

  logic pclk_q;
  logic hsync_q;
  logic vsync_q;

  logic       half_q;   // high byte waiting for its partner
  logic [7:0] high_q;

  logic [capture_pkg::HCOUNT_W-1:0] hcount_q;
  logic [capture_pkg::VCOUNT_W-1:0] vcount_q;

  logic pclk_rise;
  logic hsync_fall;
  logic vsync_rise;
  logic take_byte;
  logic pix_done;

  assign pclk_rise  = cam_bus_i.pclk & ~pclk_q;
  assign hsync_fall = ~cam_bus_i.hsync & hsync_q;
  assign vsync_rise = cam_bus_i.vsync & ~vsync_q;

  // bytes only count inside the active line
  assign take_byte = pclk_rise & cam_bus_i.hsync & ~vsync_rise;
  assign pix_done  = take_byte & half_q;   // second byte completes the pixel

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pclk_q       <= 1'b0;
      hsync_q      <= 1'b0;
      vsync_q      <= 1'b0;
      half_q       <= 1'b0;
      hcount_q     <= '0;
      vcount_q     <= '0;
      beat_valid_o <= 1'b0;
    end else begin
      pclk_q       <= cam_bus_i.pclk;
      hsync_q      <= cam_bus_i.hsync;
      vsync_q      <= cam_bus_i.vsync;
      beat_valid_o <= pix_done;
      if (vsync_rise) begin
        // new frame
        hcount_q <= '0;
        vcount_q <= '0;
        half_q   <= 1'b0;
      end else if (hsync_fall) begin
        hcount_q <= '0;
        vcount_q <= vcount_q + 1'b1;   // end of line
        half_q   <= 1'b0;              // drop a stray odd byte
      end else if (take_byte) begin
        half_q <= ~half_q;
        if (half_q) hcount_q <= hcount_q + 1'b1;
      end
    end
  end

  // payload registers load only on byte events
  always_ff @(posedge clk_camera) begin
    if (take_byte && !half_q) high_q <= cam_bus_i.data;   // first byte is msb
    if (pix_done) begin
      beat_o.pixel  <= {high_q, cam_bus_i.data};
      beat_o.hcount <= hcount_q;
      beat_o.vcount <= vcount_q;
      beat_o.last   <= (hcount_q == capture_pkg::HCOUNT_LAST) &&
                       (vcount_q == capture_pkg::VCOUNT_LAST);
    end
  end

endmodule

/* logic/stream_reg.sv */
module stream_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_camera,
  input  logic     recent_reset,
  input  logic     valid_i,
  output logic     ready_o,     // straight from a flop
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  payload_t main_q;
  payload_t skid_q;          // catches the beat taken while main stalls
  logic     main_valid_q;
  logic     skid_valid_q;

  logic in_take;
  logic out_take;
  logic main_load;

  assign ready_o   = !skid_valid_q;
  assign in_take   = valid_i && ready_o;
  assign out_take  = main_valid_q && ready_i;
  assign main_load = out_take || !main_valid_q;   // main slot free next cycle

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (main_load) begin
      main_valid_q <= skid_valid_q || in_take;   // skid drains first
      skid_valid_q <= 1'b0;
    end else if (in_take) begin
      skid_valid_q <= 1'b1;   // main stalled, park it
    end
  end

  always_ff @(posedge clk_camera) begin
    if (main_load) main_q <= skid_valid_q ? skid_q : data_i;
    if (in_take && !main_load) skid_q <= data_i;
  end

  assign valid_o = main_valid_q;
  assign data_o  = main_q;

endmodule

/* testbench/camera_checker.sv */
module camera_checker (
  input logic                       clk_camera,
  input logic                       chunk_valid_i,   // dram write side of the DUT
  input logic                       chunk_ready_i,
  input capture_pkg::chunk_t        chunk_i,
  input logic                       pixel_valid_i,   // display output of the DUT
  input logic                       pixel_ready_i,
  input capture_pkg::masked_pixel_t pixel_i
);

  capture_pkg::chunk_t        chunk_q [$];   // expected chunks, oldest first
  capture_pkg::masked_pixel_t pixel_q [$];
  capture_pkg::chunk_t        chunk_exp;
  capture_pkg::masked_pixel_t pixel_exp;

  int chunks_seen  = 0;   // per test
  int pixels_seen  = 0;
  int test_errors  = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  int total_errors = 0;

  task automatic expect_chunk(input capture_pkg::chunk_t c);
    chunk_q.push_back(c);
  endtask

  task automatic expect_pixel(input capture_pkg::masked_pixel_t p);
    pixel_q.push_back(p);
  endtask

  function automatic int pending();
    return chunk_q.size() + pixel_q.size();
  endfunction

  task automatic mismatch(input string msg);
    $display("MISMATCH at time %0t: %s", $time, msg);
    test_errors++;
  endtask

  task automatic fault(input string msg);
    $display("error at time %0t: %s", $time, msg);   // protocol or count problem
    test_errors++;
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) mismatch($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  // transfers happen on valid and ready at the edge
  always @(posedge clk_camera) begin
    if (chunk_valid_i && chunk_ready_i) begin
      if (chunk_q.size() == 0) begin
        fault("a chunk came out when none was expected");
      end else begin
        chunk_exp = chunk_q.pop_front();
        if (chunk_i !== chunk_exp) begin
          mismatch($sformatf("chunk %0d is %h, expected %h", chunks_seen, chunk_i, chunk_exp));
        end
        chunks_seen++;
      end
    end
    if (pixel_valid_i && pixel_ready_i) begin
      if (pixel_q.size() == 0) begin
        fault("a pixel came out when none was expected");   // repeated or stray
      end else begin
        pixel_exp = pixel_q.pop_front();
        if (pixel_i !== pixel_exp) begin
          mismatch($sformatf("pixel %0d is %h, expected %h", pixels_seen, pixel_i, pixel_exp));
        end
        pixels_seen++;
      end
    end
  end

  // short runs are fine when chunks were dropped on purpose
  task automatic end_test(input string name, input bit allow_short);
    if (allow_short && chunks_seen == 0) fault("no chunk was delivered at all");
    if (!allow_short && pending() != 0) begin
      fault($sformatf("%0d expected items never came out", pending()));
    end
    chunk_q.delete();
    pixel_q.delete();
    if (test_errors == 0) $display("%s: ok", name);
    else $display("%s: %0d errors", name, test_errors);
    tests_run++;
    if (test_errors != 0) tests_failed++;
    total_errors += test_errors;
    test_errors = 0;
    chunks_seen = 0;
    pixels_seen = 0;
  endtask

endmodule

/* testbench/camera_pipeline_tb.sv */
module camera_pipeline_tb;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 5;
  localparam int N_ROWS       = 4;
  localparam int FRAME_PIX    = capture_pkg::FRAME_WIDTH * capture_pkg::FRAME_HEIGHT;
  localparam int LINE_PCLKS   = 2 * capture_pkg::FRAME_WIDTH + 3;   // two bytes a pixel, junk
  localparam int FRAME_CYCLES = 12 + capture_pkg::FRAME_HEIGHT * LINE_PCLKS * 4;
  localparam int WATCHDOG     = N_ROWS * FRAME_CYCLES * 4 * CLK_PERIOD;

  // pixel i of a row is base + step * i
  typedef struct packed {
    logic [15:0]             base;
    logic [15:0]             step;
    logic [7:0]              n_pix;        // pixels sent in the capture frame
    logic [7:0]              exp_chunks;   // full chunks they make
    capture_pkg::threshold_t cutoff;
  } row_t;

  row_t rows [N_ROWS] = '{
    '{16'h0000, 16'h0421, 8'd64, 8'd8, 24'h404040},
    '{16'hF81F, 16'h1043, 8'd20, 8'd2, 24'h8020C0},   // cut short so the next frame restarts
    '{16'h1234, 16'h3579, 8'd64, 8'd8, 24'h808080},
    '{16'hFFFF, 16'hF7DF, 8'd64, 8'd8, 24'h000000}    // mask always set
  };

  logic                       clk_camera;
  logic                       recent_reset;
  capture_pkg::camera_bus_t   cam_bus_i;
  logic                       chunk_valid_o;
  logic                       chunk_ready_i;
  capture_pkg::chunk_t        chunk_o;
  logic                       overflow_o;
  logic                       chunk_valid_i;
  logic                       chunk_ready_o;
  capture_pkg::chunk_t        chunk_i;
  capture_pkg::threshold_t    cutoff_i;
  logic                       pixel_valid_o;
  logic                       pixel_ready_i;
  capture_pkg::masked_pixel_t pixel_o;
  logic                       random_ready = 1'b0;
  logic [31:0]                rng = 32'd40;   // xorshift state

  camera_pipeline DUT (.*);

  camera_checker scoreboard (
    .clk_camera    (clk_camera),
    .chunk_valid_i (chunk_valid_o),
    .chunk_ready_i (chunk_ready_i),
    .chunk_i       (chunk_o),
    .pixel_valid_i (pixel_valid_o),
    .pixel_ready_i (pixel_ready_i),
    .pixel_i       (pixel_o)
  );

  initial begin
    clk_camera = 1'b0;
    forever #(CLK_PERIOD / 2) clk_camera = ~clk_camera;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [15:0] pixel_of(input int r, input int idx);
    return rows[r].base + rows[r].step * 16'(idx);
  endfunction

  // slice 0 in the low bits
  function automatic capture_pkg::chunk_t make_chunk(input int r, input int k, input logic last);
    capture_pkg::chunk_t c;
    for (int s = 0; s < capture_pkg::PIXELS_PER_CHUNK; s++) begin
      c.data[s*capture_pkg::PIXEL_W +: capture_pkg::PIXEL_W] =
        pixel_of(r, k * capture_pkg::PIXELS_PER_CHUNK + s);
    end
    c.last = last;
    return c;
  endfunction

  // rgb565 keeps red in bits 15:11, green in 10:5 and blue in 4:0
  function automatic capture_pkg::masked_pixel_t expand_pixel(input logic [15:0] pix,
                                                              input capture_pkg::threshold_t cut,
                                                              input logic last);
    capture_pkg::masked_pixel_t m;
    m.red   = pix[15:11] * 8'd8;   // scaled to the top of the byte
    m.green = pix[10:5] * 8'd4;
    m.blue  = pix[4:0] * 8'd8;
    m.mask  = 1'b1;
    if (m.red < cut.red) m.mask = 1'b0;   // any channel below its cutoff clears it
    if (m.green < cut.green) m.mask = 1'b0;
    if (m.blue < cut.blue) m.mask = 1'b0;
    m.last  = last;
    return m;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk_camera);
      #1;   // drive just after the edge
    end
  endtask

  task automatic apply_reset();
    recent_reset = 1'b1;
    wait_cycles(RESET_CYCLES);
    recent_reset = 1'b0;
  endtask

  task automatic check_reset_state(input string name);
    scoreboard.check_flag("chunk_valid_o", chunk_valid_o, 1'b0);
    scoreboard.check_flag("pixel_valid_o", pixel_valid_o, 1'b0);
    scoreboard.check_flag("chunk_ready_o", chunk_ready_o, 1'b0);
    scoreboard.check_flag("overflow_o", overflow_o, 1'b0);
    scoreboard.end_test(name, 1'b0);
  endtask

  task automatic pclk_cycle(input logic [7:0] data, input logic hsync);
    cam_bus_i.data  = data;
    cam_bus_i.hsync = hsync;
    cam_bus_i.pclk  = 1'b0;
    wait_cycles(2);
    cam_bus_i.pclk = 1'b1;   // byte taken on this rise if hsync is high
    wait_cycles(2);
  endtask

  task automatic send_frame(input int r);
    logic [15:0] pix;
    int          n;
    n = int'(rows[r].n_pix);
    cam_bus_i.vsync = 1'b1;
    wait_cycles(4);
    cam_bus_i.vsync = 1'b0;
    wait_cycles(4);
    for (int p = 0; p < n; p++) begin
      if (p % capture_pkg::FRAME_WIDTH == 0) begin
        pclk_cycle(8'hEE, 1'b0);   // junk between lines that must be ignored
        pclk_cycle(8'hEE, 1'b0);
      end
      pix = pixel_of(r, p);
      pclk_cycle(pix[15:8], 1'b1);   // high byte first
      pclk_cycle(pix[7:0], 1'b1);
      if ((p % capture_pkg::FRAME_WIDTH == capture_pkg::FRAME_WIDTH - 1) || (p == n - 1)) begin
        pclk_cycle(8'h5A, 1'b0);   // hsync falls
      end
    end
    pclk_cycle(8'h5A, 1'b0);
  endtask

  task automatic feed_chunk(input capture_pkg::chunk_t c);
    chunk_valid_i = 1'b1;
    chunk_i       = c;
    @(posedge clk_camera);
    while (!chunk_ready_o) @(posedge clk_camera);
    #1;
    chunk_valid_i = 1'b0;
  endtask

  // bounded wait for the expected queues to empty
  task automatic wait_drained();
    int waited;
    waited = 0;
    while (scoreboard.pending() != 0 && waited < FRAME_CYCLES) begin
      wait_cycles(1);
      waited++;
    end
  endtask

  task automatic wait_quiet();
    int idle;
    idle = 0;
    while (idle < 4) begin
      @(posedge clk_camera);
      idle = chunk_valid_o ? 0 : idle + 1;
    end
    #1;
  endtask

  // random back-pressure on the pixel port
  initial begin
    pixel_ready_i = 1'b1;
    forever begin
      @(posedge clk_camera);
      #1;
      if (random_ready) begin
        rng           = xorshift32(rng);
        pixel_ready_i = rng[1:0] != 2'b00;
      end else begin
        pixel_ready_i = 1'b1;
      end
    end
  end

  initial begin
    #(WATCHDOG);
    $display("timeout: run still going after %0d time units", WATCHDOG);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    recent_reset  = 1'b1;
    cam_bus_i     = '0;
    chunk_ready_i = 1'b1;
    chunk_valid_i = 1'b0;
    chunk_i       = '0;
    cutoff_i      = '0;
    apply_reset();
    check_reset_state("reset");

    // capture with the write port always ready
    for (int r = 0; r < N_ROWS; r++) begin
      for (int k = 0; k < int'(rows[r].exp_chunks); k++) begin
        scoreboard.expect_chunk(make_chunk(r, k, k * 8 + 7 == FRAME_PIX - 1));
      end
      send_frame(r);
      wait_drained();
      scoreboard.check_flag("overflow_o", overflow_o, 1'b0);
      scoreboard.end_test($sformatf("capture row %0d", r), 1'b0);
    end

    // write port stalled for a whole frame
    chunk_ready_i = 1'b0;
    for (int k = 0; k < FRAME_PIX / 8; k++) begin
      scoreboard.expect_chunk(make_chunk(0, k, k * 8 + 7 == FRAME_PIX - 1));
    end
    send_frame(0);
    scoreboard.check_flag("overflow_o", overflow_o, 1'b1);
    chunk_ready_i = 1'b1;
    wait_quiet();
    scoreboard.check_flag("overflow_o", overflow_o, 1'b1);   // sticky
    scoreboard.end_test("overflow", 1'b1);
    apply_reset();
    check_reset_state("reset after overflow");

    // display path with one cutoff per row
    random_ready = 1'b1;
    for (int r = 0; r < N_ROWS; r++) begin
      cutoff_i = rows[r].cutoff;
      for (int k = 0; k < int'(rows[r].exp_chunks); k++) begin
        for (int s = 0; s < capture_pkg::PIXELS_PER_CHUNK; s++) begin
          scoreboard.expect_pixel(expand_pixel(pixel_of(r, k * 8 + s), rows[r].cutoff,
                                  (k == int'(rows[r].exp_chunks) - 1) && (s == 7)));
        end
      end
      for (int k = 0; k < int'(rows[r].exp_chunks); k++) begin
        feed_chunk(make_chunk(r, k, k == int'(rows[r].exp_chunks) - 1));
      end
      wait_drained();
      scoreboard.end_test($sformatf("display row %0d", r), 1'b0);
    end
    random_ready = 1'b0;

    $display("%0d tests run, %0d failed, %0d errors", scoreboard.tests_run,
             scoreboard.tests_failed, scoreboard.total_errors);
    if (scoreboard.total_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
